// ==== flist.f ====
source/camera_pkg.sv
source/pixel_reconstruct.sv
source/pixel_mask.sv
source/chunk_stacker.sv
source/capture_regs.sv
source/camera_capture_top.sv
tests/tb_clock_gen.sv
tests/camera_capture_checker.sv
tests/camera_capture_tb.sv

// ==== Bender.yml ====
package:
  name: camera_capture

sources:
  - files:
      - source/camera_pkg.sv
      - source/pixel_reconstruct.sv
      - source/pixel_mask.sv
      - source/chunk_stacker.sv
      - source/capture_regs.sv
      - source/camera_capture_top.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/camera_capture_checker.sv
      - tests/camera_capture_tb.sv

// ==== tests/camera_capture_tb.sv ====
module camera_capture_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import camera_pkg::*;

  localparam int FRAME_W      = 16;
  localparam int FRAME_H      = 4;
  localparam int FRAME_PIXELS = FRAME_W * FRAME_H;
  localparam int NUM_FRAMES   = 6;
  localparam int BYTE_CYCLES  = 4;   // one pclk period
  localparam int APB_OPS      = 40;
  localparam int APB_CYCLES   = 4;
  localparam int MARGIN       = 3000;  // sync gaps, line gaps and drain waits
  localparam int CYCLE_LIMIT  = NUM_FRAMES * FRAME_W * FRAME_H * 2 * BYTE_CYCLES +
                                APB_OPS * APB_CYCLES + MARGIN;
  localparam int NO_LINE      = -1;
  localparam logic [APB_ADDR_W-1:0] BAD_OFFSET = 4'h2;  // hole in the map

  logic                  clk_camera;
  logic                  sys_rst_camera;
  logic                  cam_pclk;
  logic                  cam_hsync;
  logic                  cam_vsync;
  logic [7:0]            cam_data;
  logic                  chunk_ready;
  chunk_stream_t         chunk;
  logic [APB_ADDR_W-1:0] paddr;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [31:0]           pwdata;
  logic [31:0]           prdata;
  logic                  pready;
  logic                  pslverr;

  integer      seed = 32'hf2ebc282;
  logic [16:0] pix_q[$];  // {last pixel of frame, raw word}
  logic [1:0]  exp_mode;
  logic [4:0]  exp_cut_r;
  logic [5:0]  exp_cut_g;
  logic [4:0]  exp_cut_b;
  int          value_errors = 0;
  int          other_errors = 0;
  int          assert_errors = 0;
  int          chunks_seen = 0;
  int          frames_expected = 0;  // frames sent with capture on
  int          cycle_count = 0;
  string       test_name = "idle";

  tb_clock_gen tb_clock_gen_inst (
    .clk_camera     (clk_camera),
    .sys_rst_camera (sys_rst_camera)
  );

  camera_capture_top camera_capture_top_inst (
    .clk_camera     (clk_camera),
    .sys_rst_camera (sys_rst_camera),
    .cam_pclk_i     (cam_pclk),
    .cam_hsync_i    (cam_hsync),
    .cam_vsync_i    (cam_vsync),
    .cam_data_i     (cam_data),
    .chunk_ready_i  (chunk_ready),
    .chunk_o        (chunk),
    .paddr_i        (paddr),
    .psel_i         (psel),
    .penable_i      (penable),
    .pwrite_i       (pwrite),
    .pwdata_i       (pwdata),
    .prdata_o       (prdata),
    .pready_o       (pready),
    .pslverr_o      (pslverr)
  );

  bind camera_capture_top camera_capture_checker camera_capture_checker_inst (
    .clk_camera     (clk_camera),
    .sys_rst_camera (sys_rst_camera),
    .chunk_i        (chunk_o),
    .chunk_ready_i  (chunk_ready_i),
    .psel_i         (psel_i),
    .penable_i      (penable_i),
    .pslverr_i      (pslverr_o),
    .pready_i       (pready_o)
  );

  // expected chunk from eight queued pixels, {last, data}
  function automatic logic [128:0] ref_chunk(input logic [135:0] group, input logic [1:0] mode,
                                             input logic [4:0] cut_r, input logic [5:0] cut_g,
                                             input logic [4:0] cut_b);
    logic [128:0] res;
    logic [15:0]  px;
    logic         hit;
    res = '0;
    for (int i = 0; i < PIXELS_PER_CHUNK; i++) begin
      px  = group[i*17 +: 16];
      hit = (px[15:11] >= cut_r) && (px[10:5] >= cut_g) && (px[4:0] >= cut_b);
      if (mode == MODE_MASK) begin
        px = hit ? 16'hffff : 16'h0000;
      end else if (mode == MODE_OVERLAY && hit) begin
        px = MAGENTA;
      end
      res[i*16 +: 16] = px;              // first pixel lands in bits 15:0
      res[128] = res[128] | group[i*17+16];
    end
    return res;
  endfunction

  // checks every accepted chunk
  always @(posedge clk_camera) begin : compare_chunks
    logic [135:0] group;
    logic [128:0] expected;
    if (!sys_rst_camera && chunk.valid && chunk_ready) begin
      chunks_seen++;
      if (pix_q.size() < PIXELS_PER_CHUNK) begin
        $display("ERROR %s: a chunk transferred with no queued pixels to match it", test_name);
        other_errors++;
      end else begin
        for (int i = 0; i < PIXELS_PER_CHUNK; i++) begin
          group[i*17 +: 17] = pix_q.pop_front();
        end
        expected = ref_chunk(group, exp_mode, exp_cut_r, exp_cut_g, exp_cut_b);
        if (chunk.data !== expected[127:0]) begin
          $display("FAIL %s: data expected %h actual %h", test_name, expected[127:0], chunk.data);
          value_errors++;
        end
        if (chunk.last !== expected[128]) begin
          $display("FAIL %s: last expected %b actual %b", test_name, expected[128], chunk.last);
          value_errors++;
        end
      end
    end
  end

  task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data);
    @(posedge clk_camera);
    paddr   <= addr;  // setup phase
    pwdata  <= data;
    pwrite  <= 1'b1;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge clk_camera);
    penable <= 1'b1;  // access, pready is always high
    @(posedge clk_camera);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output logic [31:0] data,
                          output logic err);
    @(posedge clk_camera);
    paddr   <= addr;
    pwrite  <= 1'b0;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge clk_camera);
    penable <= 1'b1;
    @(negedge clk_camera);  // read data settled mid access phase
    data = prdata;
    err  = pslverr;
    @(posedge clk_camera);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic check_register(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] mask,
                                input logic [31:0] expected);
    logic [31:0] data;
    logic        err;
    apb_read(addr, data, err);
    if (err) begin
      $display("ERROR %s: pslverr raised on a read of offset %h", test_name, addr);
      other_errors++;
    end
    if ((data & mask) !== expected) begin
      $display("FAIL %s: offset %h expected %h actual %h", test_name, addr, expected,
               data & mask);
      value_errors++;
    end
  endtask

  // call only while the stream is drained
  task automatic set_config(input logic enable, input logic [1:0] mode, input logic [4:0] cut_r,
                            input logic [5:0] cut_g, input logic [4:0] cut_b);
    exp_mode  = mode;
    exp_cut_r = cut_r;
    exp_cut_g = cut_g;
    exp_cut_b = cut_b;
    apb_write(REG_CTRL, {29'b0, mode, enable});
    apb_write(REG_CUTOFF, {11'b0, cut_b, 2'b0, cut_g, 3'b0, cut_r});
    check_register(REG_CUTOFF, 32'hffff_ffff, {11'b0, cut_b, 2'b0, cut_g, 3'b0, cut_r});
  endtask

  // one byte per pclk period, data set up half a period before the rising edge
  task automatic send_byte(input logic [7:0] b);
    cam_pclk <= 1'b0;
    cam_data <= b;
    repeat (2) @(posedge clk_camera);
    cam_pclk <= 1'b1;
    repeat (2) @(posedge clk_camera);
  endtask

  // keep = pixels of this frame expected on the stream
  task automatic send_frame(input int keep, input int enable_line);
    logic [31:0] rnd;
    logic [15:0] px;
    logic        is_last;
    int          queued;
    queued = 0;
    @(posedge clk_camera);
    cam_vsync <= 1'b1;  // frame restart
    repeat (4) @(posedge clk_camera);
    cam_vsync <= 1'b0;
    repeat (4) @(posedge clk_camera);
    for (int line = 0; line < FRAME_H; line++) begin
      if (line == enable_line) begin
        apb_write(REG_CTRL, {29'b0, exp_mode, 1'b1});  // too late for this frame
      end
      cam_hsync <= 1'b1;
      repeat (2) @(posedge clk_camera);
      for (int x = 0; x < FRAME_W; x++) begin
        rnd     = $random(seed);
        px      = rnd[15:0];
        is_last = (line == FRAME_H - 1) && (x == FRAME_W - 1);
        if (queued < keep) begin
          pix_q.push_back({is_last, px});
          queued++;
        end
        send_byte(px[15:8]);  // high byte first
        send_byte(px[7:0]);
      end
      cam_hsync <= 1'b0;  // line end
      repeat (4) @(posedge clk_camera);
    end
    if (keep == FRAME_PIXELS) begin
      frames_expected++;
    end
  endtask

  task automatic wait_drain;
    while (pix_q.size() != 0) begin
      @(posedge clk_camera);
    end
    repeat (8) @(posedge clk_camera);  // frame_done reaches the counter
  endtask

  initial begin : watchdog
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk_camera);
      cycle_count++;
    end
    $display("ERROR timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin : run_tests
    logic [31:0] rdata;
    logic        err;
    logic [31:0] rnd;
    int          base;
    cam_pclk    <= 1'b0;
    cam_hsync   <= 1'b0;
    cam_vsync   <= 1'b0;
    cam_data    <= '0;
    chunk_ready <= 1'b1;
    paddr       <= '0;
    psel        <= 1'b0;
    penable     <= 1'b0;
    pwrite      <= 1'b0;
    pwdata      <= '0;
    exp_mode    = MODE_RAW;
    exp_cut_r   = '0;
    exp_cut_g   = '0;
    exp_cut_b   = '0;
    @(negedge sys_rst_camera);

    test_name = "reset_values";
    check_register(REG_CTRL, 32'hffff_ffff, 32'h0);
    check_register(REG_CUTOFF, 32'hffff_ffff, 32'h0);
    check_register(REG_FRAME_SIZE, 32'hffff_ffff, 32'h02d0_0500);  // 720 lines of 1280
    check_register(REG_STATUS, 32'hffff_ffff, 32'h0);
    apb_read(BAD_OFFSET, rdata, err);
    if (!err) begin
      $display("ERROR %s: a read outside the register map gave no pslverr", test_name);
      other_errors++;
    end

    test_name = "raw_frame";
    apb_write(REG_FRAME_SIZE, {6'b0, 10'(FRAME_H), 5'b0, 11'(FRAME_W)});
    set_config(1'b1, MODE_RAW, 5'd0, 6'd0, 5'd0);
    base = chunks_seen;
    send_frame(FRAME_PIXELS, NO_LINE);
    wait_drain();
    if (chunks_seen - base != FRAME_PIXELS / PIXELS_PER_CHUNK) begin
      $display("ERROR %s: saw %0d chunks for one frame", test_name, chunks_seen - base);
      other_errors++;
    end

    test_name = "mask_frame";
    rnd = $random(seed);
    set_config(1'b1, MODE_MASK, {1'b0, rnd[3:0]}, {1'b0, rnd[12:8]}, {1'b0, rnd[19:16]});
    send_frame(FRAME_PIXELS, NO_LINE);
    wait_drain();

    test_name = "overlay_frame";
    rnd = $random(seed);
    set_config(1'b1, MODE_OVERLAY, {1'b0, rnd[3:0]}, {1'b0, rnd[12:8]}, {1'b0, rnd[19:16]});
    send_frame(FRAME_PIXELS, NO_LINE);
    wait_drain();

    test_name = "disabled_frame";
    set_config(1'b0, MODE_RAW, 5'd0, 6'd0, 5'd0);
    send_frame(0, 2);  // enable set before line 2
    repeat (40) @(posedge clk_camera);  // any chunk here has no pixels to match
    test_name = "enabled_next_frame";
    send_frame(FRAME_PIXELS, NO_LINE);
    wait_drain();

    test_name = "overflow_hold";
    @(posedge clk_camera);
    chunk_ready <= 1'b0;
    send_frame(PIXELS_PER_CHUNK, NO_LINE);  // only the first chunk survives
    repeat (20) @(posedge clk_camera);
    check_register(REG_STATUS, 32'h1, 32'h1);
    apb_write(REG_STATUS, 32'h1);
    check_register(REG_STATUS, 32'h1, 32'h0);
    @(posedge clk_camera);
    chunk_ready <= 1'b1;
    wait_drain();

    test_name = "frame_count";
    check_register(REG_STATUS, 32'h0000_ff00, {16'b0, 8'(frames_expected), 8'b0});

    assert_errors = camera_capture_top_inst.camera_capture_checker_inst.fail_count;
    $display("errors: %0d value, %0d other, %0d assertion, %0d chunks checked", value_errors,
             other_errors, assert_errors, chunks_seen);
    if (value_errors + other_errors + assert_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== tests/camera_capture_checker.sv ====
module camera_capture_checker (
  input logic                      clk_camera,
  input logic                      sys_rst_camera,
  input camera_pkg::chunk_stream_t chunk_i,
  input logic                      chunk_ready_i,
  input logic                      psel_i,
  input logic                      penable_i,
  input logic                      pslverr_i,
  input logic                      pready_i
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;  // failed assertions so far

  // a stalled chunk must not move
  chunk_hold_stable: assert property (@(posedge clk_camera) disable iff (sys_rst_camera)
    (chunk_i.valid && !chunk_ready_i) |=>
    (chunk_i.valid && $stable(chunk_i.data) && $stable(chunk_i.last)))
    else begin
      fail_count++;
      $error("chunk data or last changed while stalled");
    end

  // nothing on the stream straight out of reset
  chunk_idle_after_reset: assert property (@(posedge clk_camera)
    sys_rst_camera |=> !chunk_i.valid)
    else begin
      fail_count++;
      $error("chunk valid high in the cycle after reset");
    end

  apb_err_in_access: assert property (@(posedge clk_camera)
    pslverr_i |-> (psel_i && penable_i))
    else begin
      fail_count++;
      $error("pslverr outside an apb access phase");
    end

  apb_no_wait: assert property (@(posedge clk_camera) pready_i)
    else begin
      fail_count++;
      $error("pready dropped low");
    end

endmodule

// ==== tests/tb_clock_gen.sv ====
module tb_clock_gen (
  output logic clk_camera,
  output logic sys_rst_camera
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES = 5;

  initial begin
    clk_camera = 1'b0;
    forever #4 clk_camera = ~clk_camera;  // 8 ns period
  end

  initial begin
    sys_rst_camera = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_camera);
    sys_rst_camera <= 1'b0;  // released on a rising edge like the other inputs
  end

endmodule

// ==== source/camera_capture_top.sv ====
module camera_capture_top (
  input  logic                              clk_camera,
  input  logic                              sys_rst_camera,
  // camera pins, asynchronous
  input  logic                              cam_pclk_i,
  input  logic                              cam_hsync_i,
  input  logic                              cam_vsync_i,
  input  logic [7:0]                        cam_data_i,
  // chunk stream
  input  logic                              chunk_ready_i,
  output camera_pkg::chunk_stream_t         chunk_o,
  // apb slave
  input  logic [camera_pkg::APB_ADDR_W-1:0] paddr_i,
  input  logic                              psel_i,
  input  logic                              penable_i,
  input  logic                              pwrite_i,
  input  logic [31:0]                       pwdata_i,
  output logic [31:0]                       prdata_o,
  output logic                              pready_o,
  output logic                              pslverr_o
);
  import camera_pkg::*;

  capture_cfg_t   cfg;      // register block to datapath
  pixel_beat_t    pix_raw;  // reconstructed camera pixels
  pixel_beat_t    pix_out;  // after threshold and mode
  stacker_event_t events;   // overflow and frame done back to status

  capture_regs capture_regs_inst (
    .clk_camera     (clk_camera),
    .sys_rst_camera (sys_rst_camera),
    .paddr_i        (paddr_i),
    .psel_i         (psel_i),
    .penable_i      (penable_i),
    .pwrite_i       (pwrite_i),
    .pwdata_i       (pwdata_i),
    .prdata_o       (prdata_o),
    .pready_o       (pready_o),
    .pslverr_o      (pslverr_o),
    .events_i       (events),
    .cfg_o          (cfg)
  );

  pixel_reconstruct pixel_reconstruct_inst (
    .clk_camera     (clk_camera),
    .sys_rst_camera (sys_rst_camera),
    .cam_pclk_i     (cam_pclk_i),
    .cam_hsync_i    (cam_hsync_i),
    .cam_vsync_i    (cam_vsync_i),
    .cam_data_i     (cam_data_i),
    .cfg_i          (cfg),
    .pix_o          (pix_raw)
  );

  pixel_mask pixel_mask_inst (
    .clk_camera     (clk_camera),
    .sys_rst_camera (sys_rst_camera),
    .pix_i          (pix_raw),
    .cfg_i          (cfg),
    .pix_o          (pix_out)
  );

  chunk_stacker chunk_stacker_inst (
    .clk_camera     (clk_camera),
    .sys_rst_camera (sys_rst_camera),
    .pix_i          (pix_out),
    .cfg_i          (cfg),
    .chunk_ready_i  (chunk_ready_i),
    .chunk_o        (chunk_o),
    .events_o       (events)
  );

endmodule

// ==== source/capture_regs.sv ====
module capture_regs (
  input  logic                                clk_camera,
  input  logic                                sys_rst_camera,
  input  logic [camera_pkg::APB_ADDR_W-1:0]   paddr_i,
  input  logic                                psel_i,
  input  logic                                penable_i,
  input  logic                                pwrite_i,
  input  logic [31:0]                         pwdata_i,
  output logic [31:0]                         prdata_o,
  output logic                                pready_o,
  output logic                                pslverr_o,
  input  camera_pkg::stacker_event_t          events_i,
  output camera_pkg::capture_cfg_t            cfg_o
);
  import camera_pkg::*;

  capture_cfg_t cfg_q;
  logic         overflow_q;     // sticky, write 1 to clear
  logic [7:0]   frame_count_q;  // wraps at 256
  logic         access;         // apb access phase
  logic         wr_en;
  logic         addr_ok;
  logic [31:0]  rdata;

  assign access = psel_i && penable_i;
  assign wr_en  = access && pwrite_i;

  // read mux, also flags holes in the map
  always_comb begin
    addr_ok = 1'b1;
    rdata   = '0;
    case (paddr_i)
      REG_CTRL: begin
        rdata = {29'b0, cfg_q.mode, cfg_q.enable};
      end
      REG_CUTOFF: begin
        rdata = {11'b0, cfg_q.cut_blue, 2'b0, cfg_q.cut_green, 3'b0, cfg_q.cut_red};
      end
      REG_FRAME_SIZE: begin
        rdata = {6'b0, cfg_q.frame_height, 5'b0, cfg_q.frame_width};
      end
      REG_STATUS: begin
        rdata = {16'b0, frame_count_q, 7'b0, overflow_q};
      end
      default: begin
        addr_ok = 1'b0;  // unaligned offset
      end
    endcase
  end

  assign prdata_o  = rdata;
  assign pready_o  = 1'b1;  // no wait states
  assign pslverr_o = access && !addr_ok;
  assign cfg_o     = cfg_q;

  always_ff @(posedge clk_camera) begin
    if (sys_rst_camera) begin
      cfg_q         <= '{frame_width: DEFAULT_WIDTH, frame_height: DEFAULT_HEIGHT, default: '0};
      overflow_q    <= 1'b0;
      frame_count_q <= '0;
    end else begin
      if (wr_en) begin
        case (paddr_i)
          REG_CTRL: begin
            cfg_q.enable <= pwdata_i[0];
            cfg_q.mode   <= pwdata_i[2:1];
          end
          REG_CUTOFF: begin
            cfg_q.cut_red   <= pwdata_i[4:0];
            cfg_q.cut_green <= pwdata_i[13:8];
            cfg_q.cut_blue  <= pwdata_i[20:16];
          end
          REG_FRAME_SIZE: begin
            cfg_q.frame_width  <= pwdata_i[10:0];
            cfg_q.frame_height <= pwdata_i[25:16];
          end
          REG_STATUS: begin
            if (pwdata_i[0]) begin
              overflow_q <= 1'b0;  // frame count is read only
            end
          end
          default: begin
          end
        endcase
      end
      if (events_i.overflow) begin
        overflow_q <= 1'b1;  // a new overflow wins over a clear
      end
      if (events_i.frame_done) begin
        frame_count_q <= frame_count_q + 1'b1;
      end
    end
  end

endmodule

// ==== source/chunk_stacker.sv ====
module chunk_stacker (
  input  logic                       clk_camera,
  input  logic                       sys_rst_camera,
  input  camera_pkg::pixel_beat_t    pix_i,
  input  camera_pkg::capture_cfg_t   cfg_i,
  input  logic                       chunk_ready_i,
  output camera_pkg::chunk_stream_t  chunk_o,
  output camera_pkg::stacker_event_t events_o
);
  import camera_pkg::*;

  logic               capture_q;    // enable latched for the running frame
  logic [2:0]         slot_q;       // next slot in the shift word
  logic [2:0]         slot_cur;
  logic [CHUNK_W-1:0] shift_q;
  logic [CHUNK_W-1:0] shift_nxt;
  logic               frame_start;  // pixel 0,0
  logic               take;
  logic               chunk_full;   // eighth pixel of a chunk arrives
  logic               last_pix;
  logic               accept;
  logic               load;

  assign frame_start = pix_i.valid && (pix_i.hcount == '0) && (pix_i.vcount == '0);
  assign take        = pix_i.valid && (frame_start ? cfg_i.enable : capture_q);
  assign slot_cur    = frame_start ? 3'd0 : slot_q;  // realign on each frame
  assign chunk_full  = take && (slot_cur == 3'(PIXELS_PER_CHUNK - 1));
  assign last_pix    = (pix_i.hcount == cfg_i.frame_width - 1'b1) &&
                       (pix_i.vcount == cfg_i.frame_height - 1'b1);
  assign shift_nxt   = {pix_i.word.raw, shift_q[CHUNK_W-1:PIXEL_W]};  // oldest drifts down
  assign accept      = chunk_o.valid && chunk_ready_i;
  assign load        = chunk_full && (!chunk_o.valid || chunk_ready_i);  // slot free or freeing

  always_ff @(posedge clk_camera) begin
    if (take) begin
      shift_q <= shift_nxt;
    end
    if (load) begin
      chunk_o.data <= shift_nxt;
      chunk_o.last <= last_pix;  // width is a multiple of 8 so the last pixel ends a chunk
    end
    if (sys_rst_camera) begin
      capture_q     <= 1'b0;
      slot_q        <= '0;
      chunk_o.valid <= 1'b0;
      events_o      <= '0;
    end else begin
      if (frame_start) begin
        capture_q <= cfg_i.enable;  // whole frame or nothing
      end
      if (take) begin
        slot_q <= slot_cur + 1'b1;  // wraps after slot 7
      end
      if (load) begin
        chunk_o.valid <= 1'b1;
      end else if (accept) begin
        chunk_o.valid <= 1'b0;
      end
      events_o.overflow   <= chunk_full && !load;  // held chunk stays, new one is lost
      events_o.frame_done <= accept && chunk_o.last;
    end
  end

endmodule

// ==== source/pixel_mask.sv ====
module pixel_mask (
  input  logic                     clk_camera,
  input  logic                     sys_rst_camera,
  input  camera_pkg::pixel_beat_t  pix_i,
  input  camera_pkg::capture_cfg_t cfg_i,
  output camera_pkg::pixel_beat_t  pix_o
);
  import camera_pkg::*;

  logic        hit;       // all three channels reach their cutoff
  pixel_word_u word_nxt;

  // threshold straight on the rgb565 fields
  assign hit = (pix_i.word.rgb.red   >= cfg_i.cut_red)   &&
               (pix_i.word.rgb.green >= cfg_i.cut_green) &&
               (pix_i.word.rgb.blue  >= cfg_i.cut_blue);

  always_comb begin
    word_nxt = pix_i.word;
    case (cfg_i.mode)
      MODE_RAW: begin
        word_nxt = pix_i.word;
      end
      MODE_MASK: begin
        word_nxt.raw = hit ? '1 : '0;  // white where masked, black elsewhere
      end
      MODE_OVERLAY: begin
        if (hit) begin
          word_nxt.raw = MAGENTA;  // paint over the camera image
        end
      end
      default: begin
        word_nxt = pix_i.word;  // code 3 acts as raw
      end
    endcase
  end

  // one register stage, counts ride along
  always_ff @(posedge clk_camera) begin
    pix_o.word   <= word_nxt;
    pix_o.hcount <= pix_i.hcount;
    pix_o.vcount <= pix_i.vcount;
    if (sys_rst_camera) begin
      pix_o.valid <= 1'b0;
    end else begin
      pix_o.valid <= pix_i.valid;
    end
  end

endmodule

// ==== source/pixel_reconstruct.sv ====
module pixel_reconstruct (
  input  logic                     clk_camera,
  input  logic                     sys_rst_camera,
  input  logic                     cam_pclk_i,   // async to clk_camera
  input  logic                     cam_hsync_i,
  input  logic                     cam_vsync_i,
  input  logic [7:0]               cam_data_i,
  input  camera_pkg::capture_cfg_t cfg_i,
  output camera_pkg::pixel_beat_t  pix_o
);
  import camera_pkg::*;

  // two-stage synchronizers, bit 1 is the usable stage
  logic [1:0] pclk_sync;
  logic [1:0] hsync_sync;
  logic [1:0] vsync_sync;
  logic [7:0] data_meta;
  logic [7:0] data_sync;

  logic pclk_prev;
  logic hsync_prev;
  logic pclk_rise;   // rising edge of sampled pclk
  logic hsync_fall;  // end of line
  logic byte_take;   // a byte is sampled this cycle
  logic in_range;    // current position lies inside the frame

  logic                byte_phase;  // 0 waits for high byte, 1 for low byte
  logic [7:0]          high_byte;
  logic [HCOUNT_W-1:0] hcount_q;    // index of the next pixel in the line
  logic [VCOUNT_W-1:0] vcount_q;

  pixel_word_u         pix_word;
  logic [HCOUNT_W-1:0] pix_hcount;
  logic [VCOUNT_W-1:0] pix_vcount;
  logic                pix_valid;

  always_ff @(posedge clk_camera) begin
    data_meta <= cam_data_i;  // data only needs to line up with pclk
    data_sync <= data_meta;
    if (sys_rst_camera) begin
      pclk_sync  <= '0;
      hsync_sync <= '0;
      vsync_sync <= '0;
      pclk_prev  <= 1'b0;
      hsync_prev <= 1'b0;
    end else begin
      pclk_sync  <= {pclk_sync[0], cam_pclk_i};
      hsync_sync <= {hsync_sync[0], cam_hsync_i};
      vsync_sync <= {vsync_sync[0], cam_vsync_i};
      pclk_prev  <= pclk_sync[1];
      hsync_prev <= hsync_sync[1];
    end
  end

  assign pclk_rise  = pclk_sync[1] & ~pclk_prev;
  assign hsync_fall = hsync_prev & ~hsync_sync[1];
  assign byte_take  = pclk_rise & hsync_sync[1];
  assign in_range   = (hcount_q < cfg_i.frame_width) && (vcount_q < cfg_i.frame_height);

  // counters and byte phase
  always_ff @(posedge clk_camera) begin
    if (sys_rst_camera) begin
      byte_phase <= 1'b0;
      hcount_q   <= '0;
      vcount_q   <= '0;
      pix_valid  <= 1'b0;
    end else begin
      pix_valid <= 1'b0;  // one-cycle beat
      if (vsync_sync[1]) begin  // frame restart
        vcount_q   <= '0;
        hcount_q   <= '0;
        byte_phase <= 1'b0;
      end else if (hsync_fall) begin
        hcount_q   <= '0;
        byte_phase <= 1'b0;  // a half pixel at line end is dropped
        if (vcount_q < cfg_i.frame_height) begin
          vcount_q <= vcount_q + 1'b1;  // stops past the last line
        end
      end else if (byte_take) begin
        byte_phase <= ~byte_phase;
        if (byte_phase && in_range) begin  // stray bytes past the width are ignored
          pix_valid <= 1'b1;
          hcount_q  <= hcount_q + 1'b1;
        end
      end
    end
  end

  // pixel payload, qualified by pix_valid
  always_ff @(posedge clk_camera) begin
    if (byte_take && !byte_phase) begin
      high_byte <= data_sync;  // high byte comes first
    end
    if (byte_take && byte_phase) begin
      pix_word.raw <= {high_byte, data_sync};
      pix_hcount   <= hcount_q;
      pix_vcount   <= vcount_q;
    end
  end

  assign pix_o = '{word: pix_word, hcount: pix_hcount, vcount: pix_vcount, valid: pix_valid};

endmodule

// ==== source/camera_pkg.sv ====
package camera_pkg;

  // stream and pixel geometry
  localparam int PIXEL_W          = 16;
  localparam int CHUNK_W          = 128;
  localparam int PIXELS_PER_CHUNK = 8;   // CHUNK_W / PIXEL_W
  localparam int HCOUNT_W         = 11;
  localparam int VCOUNT_W         = 10;

  localparam logic [HCOUNT_W-1:0] DEFAULT_WIDTH  = 11'd1280;
  localparam logic [VCOUNT_W-1:0] DEFAULT_HEIGHT = 10'd720;

  localparam logic [PIXEL_W-1:0] MAGENTA = 16'hF81F;  // r=31 g=0 b=31

  // apb register map, byte offsets
  localparam int APB_ADDR_W = 4;
  localparam logic [APB_ADDR_W-1:0] REG_CTRL       = 4'h0;
  localparam logic [APB_ADDR_W-1:0] REG_CUTOFF     = 4'h4;
  localparam logic [APB_ADDR_W-1:0] REG_FRAME_SIZE = 4'h8;
  localparam logic [APB_ADDR_W-1:0] REG_STATUS     = 4'hC;

  // display modes, code 3 acts as raw
  localparam logic [1:0] MODE_RAW     = 2'd0;
  localparam logic [1:0] MODE_MASK    = 2'd1;
  localparam logic [1:0] MODE_OVERLAY = 2'd2;

  typedef struct packed {
    logic [4:0] red;    // bits 15:11
    logic [5:0] green;  // bits 10:5
    logic [4:0] blue;   // bits 4:0
  } rgb565_t;

  // one pixel word, seen either whole or split into colour fields
  typedef union packed {
    logic [PIXEL_W-1:0] raw;
    rgb565_t            rgb;
  } pixel_word_u;

  typedef struct packed {
    pixel_word_u         word;
    logic [HCOUNT_W-1:0] hcount;
    logic [VCOUNT_W-1:0] vcount;
    logic                valid;
  } pixel_beat_t;  // 38 bits

  typedef struct packed {
    logic [CHUNK_W-1:0] data;  // pixel 0 sits in bits 15:0
    logic               last;
    logic               valid;
  } chunk_stream_t;  // 130 bits

  typedef struct packed {
    logic                enable;
    logic [1:0]          mode;
    logic [4:0]          cut_red;
    logic [5:0]          cut_green;
    logic [4:0]          cut_blue;
    logic [HCOUNT_W-1:0] frame_width;
    logic [VCOUNT_W-1:0] frame_height;
  } capture_cfg_t;  // 40 bits

  typedef struct packed {
    logic overflow;    // chunk dropped while one was held
    logic frame_done;  // chunk with last accepted
  } stacker_event_t;

endpackage
